/* ntm_gate_pkg.sv */
// NTM write-weighting gate package
// Q4.12 fixed-point format, logistic breakpoints and the payload structs
`default_nettype none

package ntm_gate_pkg;

  //////////////////////////////////////////////////////////////////////
  // Fixed-point format
  //////////////////////////////////////////////////////////////////////

  // Q4.12 signed
  localparam int DATA_W = 16;
  localparam int FRAC_W = 12;

  typedef logic signed [DATA_W-1:0] fx_t;

  // 1.0 in Q4.12
  localparam fx_t FX_ONE = 16'sd4096;

  //////////////////////////////////////////////////////////////////////
  // Logistic approximation
  //////////////////////////////////////////////////////////////////////

  // Segment breakpoints on |x|
  localparam fx_t SIG_BP_SAT  = 16'sd20480;  // 5.0
  localparam fx_t SIG_BP_HI   = 16'sd9728;   // 2.375
  localparam fx_t SIG_BP_LO   = 16'sd4096;   // 1.0

  // Segment offsets
  localparam fx_t SIG_OFF_HI  = 16'sd3456;   // 0.84375
  localparam fx_t SIG_OFF_MID = 16'sd2560;   // 0.625
  localparam fx_t SIG_OFF_LO  = 16'sd2048;   // 0.5

  // Slopes as right shifts (1/32, 1/8, 1/4)
  localparam int SIG_SHIFT_HI  = 5;
  localparam int SIG_SHIFT_MID = 3;
  localparam int SIG_SHIFT_LO  = 2;

  //////////////////////////////////////////////////////////////////////
  // Payloads
  //////////////////////////////////////////////////////////////////////

  // Incoming request, logits plus weight elements
  typedef struct packed {
    fx_t alloc_logit;
    fx_t write_logit;
    fx_t alloc_weight;
    fx_t content_weight;
  } gate_req_t;

  // After activation, gates replace logits
  typedef struct packed {
    fx_t alloc_gate;
    fx_t write_gate;
    fx_t alloc_weight;
    fx_t content_weight;
  } gated_t;

  // Final write weighting element
  typedef struct packed {
    fx_t write_weight;
  } weight_t;

endpackage

`default_nettype wire

/* scalar_logistic.sv */
// Scalar logistic function on one Q4.12 value
// Piecewise-linear, shifts and adds only, two pipeline registers
`default_nettype none

module scalar_logistic
  import ntm_gate_pkg::*;
(
  input  wire  clk,
  input  wire  arst_n,
  input  logic in_valid,
  input  fx_t  x,
  output logic out_valid,
  output fx_t  y
);

  // Segment codes
  typedef enum logic [1:0] {
    SEG_LO,
    SEG_MID,
    SEG_HI,
    SEG_SAT
  } seg_e;

  //////////////////////////////////////////////////////////////////////
  // Stage 1 absolute value and segment select
  //////////////////////////////////////////////////////////////////////

  fx_t  x_sat;
  fx_t  x_abs;
  seg_e seg_d;

  // Stage 1 registers
  logic v1_q;
  fx_t  abs_q;
  logic neg_q;
  seg_e seg_q;

  // Most negative code has no positive twin
  assign x_sat = (x == fx_t'({1'b1, {(DATA_W-1){1'b0}}})) ? x + fx_t'(1) : x;
  assign x_abs = x_sat[DATA_W-1] ? -x_sat : x_sat;

  always_comb begin
    if (x_abs >= SIG_BP_SAT) begin
      seg_d = SEG_SAT;
    end else if (x_abs >= SIG_BP_HI) begin
      seg_d = SEG_HI;
    end else if (x_abs >= SIG_BP_LO) begin
      seg_d = SEG_MID;
    end else begin
      seg_d = SEG_LO;
    end
  end

  // Valid bit only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1_q <= 1'b0;
    end else begin
      v1_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    abs_q <= x_abs;
    neg_q <= x_sat[DATA_W-1];
    seg_q <= seg_d;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2 shift-add and reflection
  //////////////////////////////////////////////////////////////////////

  fx_t y_pos;
  fx_t y_d;

  always_comb begin
    case (seg_q)
      SEG_SAT: y_pos = FX_ONE;
      SEG_HI:  y_pos = (abs_q >>> SIG_SHIFT_HI) + SIG_OFF_HI;
      SEG_MID: y_pos = (abs_q >>> SIG_SHIFT_MID) + SIG_OFF_MID;
      default: y_pos = (abs_q >>> SIG_SHIFT_LO) + SIG_OFF_LO;
    endcase
  end

  // sigma(-x) = 1 - sigma(x)
  assign y_d = neg_q ? FX_ONE - y_pos : y_pos;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= v1_q;
    end
  end

  always_ff @(posedge clk) begin
    y <= y_d;
  end

  // Result always a probability
  a_y_range: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> (y >= 0 && y <= FX_ONE));

endmodule

`default_nettype wire

/* credit_fifo.sv */
// Receiver-side credit buffer, generic over its payload type
// Returns one credit pulse for every item popped
`default_nettype none

module credit_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      arst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage
  payload_t mem [DEPTH];

  // Pointers and fill level
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic do_pop;

  assign not_empty = (count != '0);
  assign do_pop    = pop && not_empty;

  // Slot freed, hand a credit back now
  assign credit    = do_pop;

  // Head of queue, combinational read
  assign pop_data  = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged
      if (push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Sender overran its credits
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> (count < CNT_W'(DEPTH) || do_pop));

  // Consumer popped nothing
  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> not_empty);

endmodule

`default_nettype wire

/* gate_activation_stage.sv */
// Gate activation stage
// Applies the logistic to both logits and forwards gates with the weights
`default_nettype none

module gate_activation_stage
  import ntm_gate_pkg::*;
#(
  parameter int MID_DEPTH = 4
) (
  input  wire       clk,
  input  wire       arst_n,
  input  gate_req_t req,
  input  logic      req_avail,
  output logic      req_pop,
  output logic      mid_valid,
  output gated_t    mid_data,
  input  logic      mid_credit
);

  localparam int CNT_W = $clog2(MID_DEPTH + 1);

  //////////////////////////////////////////////////////////////////////
  // Mid link credits
  //////////////////////////////////////////////////////////////////////

  logic [CNT_W-1:0] credit_cnt;

  // Credit is taken at pop so in-flight items always own a slot
  assign req_pop = req_avail && (credit_cnt != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CNT_W'(MID_DEPTH);
    end else if (req_pop && !mid_credit) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (mid_credit && !req_pop) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Logistic pipelines
  //////////////////////////////////////////////////////////////////////

  logic alloc_valid;
  logic write_valid;
  fx_t  alloc_gate;
  fx_t  write_gate;

  // g_a
  scalar_logistic u_alloc_logistic (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (req_pop),
    .x        (req.alloc_logit),
    .out_valid(alloc_valid),
    .y        (alloc_gate)
  );

  // g_w
  scalar_logistic u_write_logistic (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (req_pop),
    .x        (req.write_logit),
    .out_valid(write_valid),
    .y        (write_gate)
  );

  //////////////////////////////////////////////////////////////////////
  // Weight side pipe
  //////////////////////////////////////////////////////////////////////

  // Two stages, matching the logistic latency
  fx_t a_q1;
  fx_t c_q1;
  fx_t a_q2;
  fx_t c_q2;

  always_ff @(posedge clk) begin
    a_q1 <= req.alloc_weight;
    c_q1 <= req.content_weight;
    a_q2 <= a_q1;
    c_q2 <= c_q1;
  end

  assign mid_valid = alloc_valid && write_valid;

  assign mid_data.alloc_gate     = alloc_gate;
  assign mid_data.write_gate     = write_gate;
  assign mid_data.alloc_weight   = a_q2;
  assign mid_data.content_weight = c_q2;

  // Never more credits than the mid buffer holds
  a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
    credit_cnt <= CNT_W'(MID_DEPTH));

endmodule

`default_nettype wire

/* weighting_blend_stage.sv */
// Write-weighting blend stage
// w = g_w * (g_a * a + (1 - g_a) * c), two pipeline registers
`default_nettype none

module weighting_blend_stage
  import ntm_gate_pkg::*;
#(
  parameter int OUT_CREDITS = 2
) (
  input  wire     clk,
  input  wire     arst_n,
  input  gated_t  mid,
  input  logic    mid_avail,
  output logic    mid_pop,
  output logic    out_valid,
  output weight_t out_weight,
  input  logic    out_credit
);

  localparam int CNT_W  = $clog2(OUT_CREDITS + 1);
  localparam int PROD_W = 2 * DATA_W + 2;

  //////////////////////////////////////////////////////////////////////
  // Output credits
  //////////////////////////////////////////////////////////////////////

  logic [CNT_W-1:0] credit_cnt;
  logic [1:0]       in_flight;
  logic             v1_q;

  // Items popped but not yet charged to the counter
  assign in_flight = {1'b0, v1_q} + {1'b0, out_valid};

  // Pop only with a credit left over after in-flight items
  assign mid_pop = mid_avail && (int'(credit_cnt) > int'(in_flight));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CNT_W'(OUT_CREDITS);
    end else if (out_valid && !out_credit) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (out_credit && !out_valid) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 1 interpolation
  //////////////////////////////////////////////////////////////////////

  logic signed [DATA_W:0]   ga_ext;
  logic signed [DATA_W:0]   one_minus_ga;
  logic signed [PROD_W-1:0] mix_sum;
  fx_t                      t_d;

  // Registered interpolation and write gate
  fx_t t_q;
  fx_t gw_q;

  // 17 bits so 1 - g_a stays exact
  assign ga_ext       = mid.alloc_gate;
  assign one_minus_ga = FX_ONE - ga_ext;

  // Full-width sum, one truncating shift
  assign mix_sum = ga_ext * mid.alloc_weight + one_minus_ga * mid.content_weight;
  assign t_d     = fx_t'(mix_sum >>> FRAC_W);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1_q <= 1'b0;
    end else begin
      v1_q <= mid_pop;
    end
  end

  always_ff @(posedge clk) begin
    t_q  <= t_d;
    gw_q <= mid.write_gate;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2 write gate scaling
  //////////////////////////////////////////////////////////////////////

  logic signed [2*DATA_W-1:0] scale_prod;

  assign scale_prod = gw_q * t_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= v1_q;
    end
  end

  always_ff @(posedge clk) begin
    out_weight.write_weight <= fx_t'(scale_prod >>> FRAC_W);
  end

  // Counter within the sink's grant
  a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
    credit_cnt <= CNT_W'(OUT_CREDITS));

  // Every output is covered by a credit
  a_credit_min: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> (credit_cnt != '0));

endmodule

`default_nettype wire

/* ntm_write_weighting.sv */
// NTM write-weighting gate path, top level
// Input buffer, activation, mid buffer and blend chained by credit links
`default_nettype none

module ntm_write_weighting
  import ntm_gate_pkg::*;
#(
  parameter int IN_DEPTH    = 4,
  parameter int MID_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  wire       clk,
  input  wire       arst_n,
  input  logic      in_valid,
  input  gate_req_t in_req,
  output logic      in_credit,
  output logic      out_valid,
  output weight_t   out_weight,
  input  logic      out_credit
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////

  // Input buffer to activation
  gate_req_t req_head;
  logic      req_avail;
  logic      req_pop;

  // Activation to mid buffer
  logic      mid_valid;
  gated_t    mid_data;
  logic      mid_credit;

  // Mid buffer to blend
  gated_t    mid_head;
  logic      mid_avail;
  logic      mid_pop;

  // Request buffer, credits go back to the external source
  credit_fifo #(
    .DEPTH    (IN_DEPTH),
    .payload_t(gate_req_t)
  ) u_in_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (in_valid),
    .push_data(in_req),
    .pop      (req_pop),
    .pop_data (req_head),
    .not_empty(req_avail),
    .credit   (in_credit)
  );

  gate_activation_stage #(
    .MID_DEPTH(MID_DEPTH)
  ) u_activation (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req_head),
    .req_avail (req_avail),
    .req_pop   (req_pop),
    .mid_valid (mid_valid),
    .mid_data  (mid_data),
    .mid_credit(mid_credit)
  );

  // Gated values wait here for the blend stage
  credit_fifo #(
    .DEPTH    (MID_DEPTH),
    .payload_t(gated_t)
  ) u_mid_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (mid_valid),
    .push_data(mid_data),
    .pop      (mid_pop),
    .pop_data (mid_head),
    .not_empty(mid_avail),
    .credit   (mid_credit)
  );

  weighting_blend_stage #(
    .OUT_CREDITS(OUT_CREDITS)
  ) u_blend (
    .clk       (clk),
    .arst_n    (arst_n),
    .mid       (mid_head),
    .mid_avail (mid_avail),
    .mid_pop   (mid_pop),
    .out_valid (out_valid),
    .out_weight(out_weight),
    .out_credit(out_credit)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 10 ns clock, active-low reset held for 10 cycles
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after a rising edge, clear of both sampling edges
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_ntm_write_weighting.sv */
// NTM write-weighting testbench
// Credit-based source and sink, reference model, compare tasks and report
`default_nettype none

module tb_ntm_write_weighting
  import ntm_gate_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IN_DEPTH    = 4;
  localparam int MID_DEPTH   = 4;
  localparam int OUT_CREDITS = 2;
  localparam int WAIT_LIMIT  = 5000;

  // Q4.12 constants
  localparam fx_t ONE       = 16'sd4096;
  localparam fx_t LOGIT_HI  = 16'sd24576;   // 6.0
  localparam fx_t LOGIT_MAX = 16'sd28672;   // 7.0
  localparam fx_t LOGIT_MIN = fx_t'(16'h8000);  // -8.0, most negative code

  logic      clk;
  logic      arst_n;
  logic      in_valid   = 1'b0;
  gate_req_t in_req     = '0;
  logic      in_credit;
  logic      out_valid;
  weight_t   out_weight;
  logic      out_credit = 1'b0;

  // Every segment, both signs, saturation
  fx_t seg_logits [13] = '{16'sd0, 16'sd2048, -16'sd2048, 16'sd4096, -16'sd4096,
                           16'sd8192, -16'sd8192, 16'sd9728, -16'sd9728,
                           16'sd16384, -16'sd16384, 16'sd28672, -16'sd28672};

  // Pending stimulus and expected results, in order
  gate_req_t stim_q [$];
  weight_t   exp_q [$];
  string     name_q [$];

  int unsigned lcg_state = 32'd4132;
  int src_credits = IN_DEPTH;
  int sink_credits = OUT_CREDITS;
  int owed = 0;
  int ret_delay = 0;
  int n_sent = 0;
  int in_credit_total = 0;
  int out_count = 0;
  bit hold_credits = 1'b0;
  int weight_errors = 0;
  int count_errors = 0;
  int other_errors = 0;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .arst_n(arst_n)
  );

  ntm_write_weighting #(
    .IN_DEPTH   (IN_DEPTH),
    .MID_DEPTH  (MID_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_weight(out_weight),
    .out_credit(out_credit)
  );

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Symmetric logit range, most negative code left out
  function automatic fx_t rand_logit();
    fx_t v;
    v = fx_t'(lcg_next() >> 16);
    if (v == fx_t'(16'h8000)) v = fx_t'(16'h8001);
    return v;
  endfunction

  // Weight in [0, 1]
  function automatic fx_t rand_weight();
    return fx_t'((lcg_next() >> 8) % 32'd4097);
  endfunction

  function automatic fx_t ref_logistic(fx_t x);
    int xi;
    int ax;
    int y;
    xi = int'(x);
    if (xi == -32768) xi = -32767;
    ax = (xi < 0) ? -xi : xi;
    // Saturation at 5.0, then slopes 1/32, 1/8, 1/4
    if (ax >= 20480) y = 4096;
    else if (ax >= 9728) y = (ax >> 5) + 3456;
    else if (ax >= 4096) y = (ax >> 3) + 2560;
    else y = (ax >> 2) + 2048;
    if (xi < 0) y = 4096 - y;
    return fx_t'(y);
  endfunction

  function automatic weight_t ref_weight(gate_req_t r);
    longint ga;
    longint gw;
    longint mix;
    longint t;
    weight_t w;
    ga  = longint'(ref_logistic(r.alloc_logit));
    gw  = longint'(ref_logistic(r.write_logit));
    mix = ga * r.alloc_weight + (64'sd4096 - ga) * r.content_weight;
    // Truncating arithmetic shifts, as in the blend rule
    t   = longint'(fx_t'(mix >>> 12));
    w.write_weight = fx_t'((gw * t) >>> 12);
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and report
  //////////////////////////////////////////////////////////////////////

  task automatic check_weight(string name, weight_t expected, weight_t actual);
    if (actual !== expected) begin
      weight_errors++;
      $display("ERROR %s expected %0d actual %0d", name,
               expected.write_weight, actual.write_weight);
    end
  endtask

  task automatic check_count(string name, int expected, int actual);
    if (actual != expected) begin
      count_errors++;
      $display("ERROR %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_limit(string name, int limit, int actual);
    if (actual > limit) begin
      count_errors++;
      $display("ERROR %s expected at most %0d actual %0d", name, limit, actual);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d weight, %0d count, %0d other",
             weight_errors, count_errors, other_errors);
    if (weight_errors + count_errors + other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic queue_req(string name, fx_t alloc_logit, fx_t write_logit,
                           fx_t a, fx_t c);
    gate_req_t r;
    r.alloc_logit    = alloc_logit;
    r.write_logit    = write_logit;
    r.alloc_weight   = a;
    r.content_weight = c;
    stim_q.push_back(r);
    exp_q.push_back(ref_weight(r));
    name_q.push_back(name);
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (!arst_n) begin
      if (cycles == WAIT_LIMIT) begin
        $display("Timeout: reset was never released");
        other_errors++;
        finish_run();
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  // All sent, all outputs seen, all credits back with the DUT
  task automatic wait_drained(string name);
    int cycles;
    cycles = 0;
    while (stim_q.size() != 0 || exp_q.size() != 0 || owed != 0) begin
      if (cycles == WAIT_LIMIT) begin
        $display("Timeout: %s still had %0d outputs pending", name, exp_q.size());
        other_errors++;
        finish_run();
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Credit-based source and sink
  //////////////////////////////////////////////////////////////////////

  // Source side, one request per cycle while credits last
  always @(negedge clk) begin
    if (!arst_n) begin
      src_credits = IN_DEPTH;
      in_valid <= 1'b0;
    end else begin
      if (in_credit) begin
        src_credits++;
        in_credit_total++;
      end
      if (src_credits > IN_DEPTH) begin
        other_errors++;
        $display("Input buffer returned more credits than its depth");
      end
      in_valid <= 1'b0;
      if (stim_q.size() > 0 && src_credits > 0) begin
        in_req   <= stim_q.pop_front();
        in_valid <= 1'b1;
        src_credits--;
        n_sent++;
      end
    end
  end

  // Sink side, checks each output and returns its credit after a delay
  always @(negedge clk) begin
    if (!arst_n) begin
      sink_credits = OUT_CREDITS;
      owed = 0;
      ret_delay = 0;
      out_credit <= 1'b0;
    end else begin
      out_credit <= 1'b0;
      if (out_valid) begin
        out_count++;
        owed++;
        if (sink_credits == 0) begin
          other_errors++;
          $display("Output arrived while the DUT held no sink credit");
        end else begin
          sink_credits--;
        end
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Output arrived with no request pending");
        end else begin
          check_weight(name_q.pop_front(), exp_q.pop_front(), out_weight);
        end
      end
      if (!hold_credits && owed > 0) begin
        if (ret_delay == 0) begin
          out_credit <= 1'b1;
          owed--;
          sink_credits++;
          ret_delay = int'(lcg_next() >> 30);
        end else begin
          ret_delay--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int ic_mid;
    int sent_before;
    int out_before;
    wait_reset();

    // Quiet after reset, nothing sent yet
    repeat (20) @(posedge clk);
    check_count("idle in_credit pulses", 0, in_credit_total);
    check_count("idle out_valid pulses", 0, out_count);

    // g_w saturated to 1, a = 1, c = 0 so the output is g_a
    foreach (seg_logits[i]) begin
      queue_req("logistic_segments", seg_logits[i], LOGIT_HI, ONE, 16'sd0);
    end
    wait_drained("logistic_segments");

    // g_a at 0 or 1 selects c or a
    for (int i = 0; i < 8; i++) begin
      queue_req("interp_ends", (i % 2 == 0) ? LOGIT_MIN : LOGIT_MAX,
                rand_logit(), rand_weight(), rand_weight());
    end
    wait_drained("interp_ends");

    for (int i = 0; i < 200; i++) begin
      queue_req("random", rand_logit(), rand_logit(), rand_weight(), rand_weight());
    end
    wait_drained("random");

    // Sink stalls, buffers fill, in_credit stops
    hold_credits = 1'b1;
    sent_before  = n_sent;
    out_before   = out_count;
    for (int i = 0; i < 20; i++) begin
      queue_req("back_pressure", rand_logit(), rand_logit(), rand_weight(), rand_weight());
    end
    repeat (30) @(posedge clk);
    ic_mid = in_credit_total;
    repeat (20) @(posedge clk);
    check_limit("outputs while held", OUT_CREDITS, out_count - out_before);
    check_limit("requests accepted while held", IN_DEPTH + MID_DEPTH + 4,
                n_sent - sent_before);
    check_count("in_credit pulses late in hold", ic_mid, in_credit_total);
    hold_credits = 1'b0;
    wait_drained("back_pressure");

    // Conservation
    check_count("in_credit total", n_sent, in_credit_total);
    check_count("outputs total", n_sent, out_count);
    finish_run();
  end

endmodule

`default_nettype wire

/* sources.f */
ntm_gate_pkg.sv
scalar_logistic.sv
credit_fifo.sv
gate_activation_stage.sv
weighting_blend_stage.sv
ntm_write_weighting.sv
tb_clock_gen.sv
tb_ntm_write_weighting.sv

/* Makefile */
TOP  := tb_ntm_write_weighting
SRCS := $(shell cat sources.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
